// ==== design/mem_port_pkg.sv ====
// Shared widths and types; word address is host address bits 28:2, QUEUE_DEPTH must be a power of two
`default_nettype none

package mem_port_pkg;

	// ============================================================
	// Widths and sizes
	// ============================================================
	localparam int ADDR_W      = 32;	// Host byte address
	localparam int DATA_W      = 32;	// One controller word
	localparam int WORD_ADDR_W = 27;	// Controller local address
	localparam int WORD_LSB    = 2;	// Lowest host address bit of the word address

	localparam int QUEUE_DEPTH = 4;
	localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
	localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);	// Count must reach QUEUE_DEPTH

	// ============================================================
	// Commands and states
	// ============================================================
	// Encoding follows the host i_rw flag, low means read
	typedef enum logic {
		OP_READ  = 1'b0,
		OP_WRITE = 1'b1
	} mem_op_e;

	typedef struct packed {
		mem_op_e                op;
		logic [WORD_ADDR_W-1:0] addr;
		logic [DATA_W-1:0]      data;
	} mem_cmd_t;

	typedef enum logic [1:0] {
		SEQ_IDLE      = 2'd0,
		SEQ_WRITE_ACK = 2'd1,
		SEQ_READ_WAIT = 2'd2,
		SEQ_READ_ACK  = 2'd3
	} seq_state_e;

	typedef enum logic [1:0] {
		DRV_IDLE      = 2'd0,
		DRV_ISSUE     = 2'd1,
		DRV_READ_WAIT = 2'd2
	} drv_state_e;

endpackage

`default_nettype wire

// ==== design/cmd_queue_if.sv ====
// Command queue link; push only while full is low, pop only while empty is low, head valid when not empty
`timescale 1ns/100ps
`default_nettype none

interface cmd_queue_if;

	// Write side
	logic                   push;
	mem_port_pkg::mem_cmd_t push_cmd;
	logic                   full;

	// Read side
	logic                   pop;
	mem_port_pkg::mem_cmd_t pop_cmd;	// Head entry
	logic                   empty;

	modport writer (
		output push,
		output push_cmd,
		input  full
	);

	modport store (
		input  push,
		input  push_cmd,
		input  pop,
		output full,
		output pop_cmd,
		output empty
	);

	modport reader (
		output pop,
		input  pop_cmd,
		input  empty
	);

endinterface

`default_nettype wire

// ==== design/host_request_sequencer.sv ====
// Host side of the bridge; i_request is a level, writes are acked once queued, one read in flight at a time
`timescale 1ns/100ps
`default_nettype none

module host_request_sequencer (
	input  logic                              i_clock,
	input  logic                              i_reset,

	input  logic                              i_request,
	input  logic                              i_rw,	// High for write
	input  logic [mem_port_pkg::ADDR_W-1:0]   i_address,
	input  logic [mem_port_pkg::DATA_W-1:0]   i_wdata,
	output logic [mem_port_pkg::DATA_W-1:0]   o_rdata,
	output logic                              o_ready,

	input  logic                              i_rsp_valid,
	input  logic [mem_port_pkg::DATA_W-1:0]   i_rsp_data,

	cmd_queue_if.writer                       q
);

	mem_port_pkg::seq_state_e state;
	mem_port_pkg::seq_state_e next_state;
	mem_port_pkg::mem_cmd_t   req_cmd;
	logic                     accept;

	// ============================================================
	// Request capture
	// ============================================================
	always_comb begin
		req_cmd.op   = mem_port_pkg::mem_op_e'(i_rw);
		req_cmd.addr = i_address[mem_port_pkg::WORD_LSB +: mem_port_pkg::WORD_ADDR_W];	// Upper bits dropped
		req_cmd.data = i_wdata;
	end

	assign accept = (state == mem_port_pkg::SEQ_IDLE) && i_request && !q.full;

	assign q.push     = accept;
	assign q.push_cmd = req_cmd;

	// ============================================================
	// State machine
	// ============================================================
	always_comb begin
		next_state = state;
		case (state)
			mem_port_pkg::SEQ_IDLE: begin
				if (accept) begin
					if (req_cmd.op == mem_port_pkg::OP_WRITE)
						next_state = mem_port_pkg::SEQ_WRITE_ACK;	// Posted, ack right away
					else
						next_state = mem_port_pkg::SEQ_READ_WAIT;
				end
			end
			mem_port_pkg::SEQ_WRITE_ACK: begin
				next_state = mem_port_pkg::SEQ_IDLE;
			end
			mem_port_pkg::SEQ_READ_WAIT: begin
				if (i_rsp_valid)
					next_state = mem_port_pkg::SEQ_READ_ACK;
			end
			mem_port_pkg::SEQ_READ_ACK: begin
				next_state = mem_port_pkg::SEQ_IDLE;
			end
			default: begin
				next_state = mem_port_pkg::SEQ_IDLE;
			end
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= mem_port_pkg::SEQ_IDLE;
		end
		else begin
			state <= next_state;
		end
	end

	// Read data lands here one cycle ahead of the ready pulse
	always_ff @(posedge i_clock) begin
		if ((state == mem_port_pkg::SEQ_READ_WAIT) && i_rsp_valid) begin
			o_rdata <= i_rsp_data;
		end
	end

	assign o_ready = (state == mem_port_pkg::SEQ_WRITE_ACK) ||
	                 (state == mem_port_pkg::SEQ_READ_ACK);

	// ============================================================
	// Assertions
	// ============================================================
	// A held request must be seen again as a new one, never acked twice in a row
	ready_single_pulse: assert property (
		@(posedge i_clock) disable iff (i_reset)
		o_ready |=> !o_ready
	) else $error("o_ready high on two consecutive cycles");

endmodule

`default_nettype wire

// ==== design/cmd_queue.sv ====
// Synchronous command FIFO of QUEUE_DEPTH entries; depth must be a power of two, no push while full
`timescale 1ns/100ps
`default_nettype none

module cmd_queue (
	input  logic       i_clock,
	input  logic       i_reset,

	cmd_queue_if.store q
);

	mem_port_pkg::mem_cmd_t               mem [mem_port_pkg::QUEUE_DEPTH];
	logic [mem_port_pkg::QUEUE_PTR_W-1:0] wr_ptr;
	logic [mem_port_pkg::QUEUE_PTR_W-1:0] rd_ptr;
	logic [mem_port_pkg::QUEUE_CNT_W-1:0] count;

	// ============================================================
	// Storage
	// ============================================================
	always_ff @(posedge i_clock) begin
		if (q.push) begin
			mem[wr_ptr] <= q.push_cmd;
		end
	end

	assign q.pop_cmd = mem[rd_ptr];	// Head shows up once count is nonzero

	// ============================================================
	// Pointers and occupancy
	// ============================================================
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else begin
			if (q.push)
				wr_ptr <= wr_ptr + 1'b1;	// Wraps at the power of two
			if (q.pop)
				rd_ptr <= rd_ptr + 1'b1;

			case ({q.push, q.pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign q.full  = (count == mem_port_pkg::QUEUE_CNT_W'(mem_port_pkg::QUEUE_DEPTH));
	assign q.empty = (count == '0);

	// ============================================================
	// Assertions
	// ============================================================
	// The sequencer must honour full
	no_push_when_full: assert property (
		@(posedge i_clock) disable iff (i_reset)
		q.full |-> !q.push
	) else $error("Command queue pushed while full");

	// The driver must honour empty
	no_pop_when_empty: assert property (
		@(posedge i_clock) disable iff (i_reset)
		q.empty |-> !q.pop
	) else $error("Command queue popped while empty");

endmodule

`default_nettype wire

// ==== design/avl_port_driver.sv ====
// Controller local port driver; single-word transfers, one read outstanding, commands wait for init-done
`timescale 1ns/100ps
`default_nettype none

module avl_port_driver (
	input  logic                                 i_clock,
	input  logic                                 i_reset,

	input  logic                                 i_local_init_done,
	input  logic                                 i_avl_ready,
	input  logic                                 i_avl_rdata_valid,
	input  logic [mem_port_pkg::DATA_W-1:0]      i_avl_rdata,
	output logic                                 o_avl_read_req,
	output logic                                 o_avl_write_req,
	output logic                                 o_avl_burstbegin,
	output logic [mem_port_pkg::WORD_ADDR_W-1:0] o_avl_addr,
	output logic [mem_port_pkg::DATA_W-1:0]      o_avl_wdata,

	output logic                                 o_rsp_valid,
	output logic [mem_port_pkg::DATA_W-1:0]      o_rsp_data,

	cmd_queue_if.reader                          q
);

	mem_port_pkg::drv_state_e state;
	mem_port_pkg::drv_state_e next_state;
	mem_port_pkg::mem_cmd_t   hold_cmd;
	logic                     take;
	logic                     issuing;

	assign take    = (state == mem_port_pkg::DRV_IDLE) && !q.empty && i_local_init_done;
	assign issuing = (state == mem_port_pkg::DRV_ISSUE);

	assign q.pop = take;

	// The popped command stays put until the controller takes it
	always_ff @(posedge i_clock) begin
		if (take) begin
			hold_cmd <= q.pop_cmd;
		end
	end

	// ============================================================
	// State machine
	// ============================================================
	always_comb begin
		next_state = state;
		case (state)
			mem_port_pkg::DRV_IDLE: begin
				if (take)
					next_state = mem_port_pkg::DRV_ISSUE;
			end
			mem_port_pkg::DRV_ISSUE: begin
				if (i_avl_ready) begin
					if (hold_cmd.op == mem_port_pkg::OP_WRITE)
						next_state = mem_port_pkg::DRV_IDLE;
					else
						next_state = mem_port_pkg::DRV_READ_WAIT;
				end
			end
			mem_port_pkg::DRV_READ_WAIT: begin
				if (i_avl_rdata_valid)
					next_state = mem_port_pkg::DRV_IDLE;
			end
			default: begin
				next_state = mem_port_pkg::DRV_IDLE;
			end
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state       <= mem_port_pkg::DRV_IDLE;
			o_rsp_valid <= 1'b0;
		end
		else begin
			state       <= next_state;
			o_rsp_valid <= (state == mem_port_pkg::DRV_READ_WAIT) && i_avl_rdata_valid;
		end
	end

	always_ff @(posedge i_clock) begin
		if ((state == mem_port_pkg::DRV_READ_WAIT) && i_avl_rdata_valid) begin
			o_rsp_data <= i_avl_rdata;
		end
	end

	// ============================================================
	// Controller port
	// ============================================================
	assign o_avl_read_req   = issuing && (hold_cmd.op == mem_port_pkg::OP_READ);
	assign o_avl_write_req  = issuing && (hold_cmd.op == mem_port_pkg::OP_WRITE);
	assign o_avl_burstbegin = o_avl_read_req || o_avl_write_req;	// Every transfer is one beat
	assign o_avl_addr       = hold_cmd.addr;
	assign o_avl_wdata      = hold_cmd.data;

	// ============================================================
	// Assertions
	// ============================================================
	one_request_at_a_time: assert property (
		@(posedge i_clock) disable iff (i_reset)
		!(o_avl_read_req && o_avl_write_req)
	) else $error("Read and write requests high together");

	// A stalled request must not change under the controller
	request_held_until_ready: assert property (
		@(posedge i_clock) disable iff (i_reset)
		(o_avl_read_req || o_avl_write_req) && !i_avl_ready |=>
			$stable(o_avl_addr) && $stable(o_avl_wdata) &&
			$stable(o_avl_read_req) && $stable(o_avl_write_req)
	) else $error("Controller request changed before ready");

endmodule

`default_nettype wire

// ==== design/mem_port_bridge.sv ====
// Host to memory controller bridge; word address is i_address[28:2], 32-bit words, all byte lanes written
`timescale 1ns/100ps
`default_nettype none

module mem_port_bridge (
	input  logic                                 i_clock,
	input  logic                                 i_reset,

	// Host bus
	input  logic                                 i_request,
	input  logic                                 i_rw,
	input  logic [mem_port_pkg::ADDR_W-1:0]      i_address,
	input  logic [mem_port_pkg::DATA_W-1:0]      i_wdata,
	output logic [mem_port_pkg::DATA_W-1:0]      o_rdata,
	output logic                                 o_ready,

	// Controller local command port
	input  logic                                 i_local_init_done,
	input  logic                                 i_avl_ready,
	input  logic                                 i_avl_rdata_valid,
	input  logic [mem_port_pkg::DATA_W-1:0]      i_avl_rdata,
	output logic                                 o_avl_read_req,
	output logic                                 o_avl_write_req,
	output logic                                 o_avl_burstbegin,
	output logic [mem_port_pkg::WORD_ADDR_W-1:0] o_avl_addr,
	output logic [mem_port_pkg::DATA_W-1:0]      o_avl_wdata
);

	logic                              rsp_valid;
	logic [mem_port_pkg::DATA_W-1:0]   rsp_data;

	cmd_queue_if cmd_q ();

	host_request_sequencer u_sequencer (
		.i_clock     (i_clock),
		.i_reset     (i_reset),
		.i_request   (i_request),
		.i_rw        (i_rw),
		.i_address   (i_address),
		.i_wdata     (i_wdata),
		.o_rdata     (o_rdata),
		.o_ready     (o_ready),
		.i_rsp_valid (rsp_valid),
		.i_rsp_data  (rsp_data),
		.q           (cmd_q.writer)
	);

	cmd_queue u_queue (
		.i_clock (i_clock),
		.i_reset (i_reset),
		.q       (cmd_q.store)
	);

	avl_port_driver u_driver (
		.i_clock           (i_clock),
		.i_reset           (i_reset),
		.i_local_init_done (i_local_init_done),
		.i_avl_ready       (i_avl_ready),
		.i_avl_rdata_valid (i_avl_rdata_valid),
		.i_avl_rdata       (i_avl_rdata),
		.o_avl_read_req    (o_avl_read_req),
		.o_avl_write_req   (o_avl_write_req),
		.o_avl_burstbegin  (o_avl_burstbegin),
		.o_avl_addr        (o_avl_addr),
		.o_avl_wdata       (o_avl_wdata),
		.o_rsp_valid       (rsp_valid),
		.o_rsp_data        (rsp_data),
		.q                 (cmd_q.reader)
	);

endmodule

`default_nettype wire

// ==== sim/tb_clock_gen.sv ====
// Free-running testbench clock with a 20 ns period, starts low at time zero
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
	output logic o_clock
);

	initial o_clock = 1'b0;

	always #10 o_clock = ~o_clock;	// Half of the 20 ns period

endmodule

`default_nettype wire

// ==== sim/avl_memory_model.sv ====
// Behavioral controller port; one read outstanding, storage survives reset, unwritten words read zero
`timescale 1ns/100ps
`default_nettype none

module avl_memory_model (
	input  logic                                 i_clock,
	input  logic                                 i_reset,
	input  logic                                 i_force_stall,
	input  logic                                 i_read_req,
	input  logic                                 i_write_req,
	input  logic [mem_port_pkg::WORD_ADDR_W-1:0] i_addr,
	input  logic [mem_port_pkg::DATA_W-1:0]      i_wdata,
	output logic                                 o_init_done,
	output logic                                 o_ready,
	output logic                                 o_rdata_valid,
	output logic [mem_port_pkg::DATA_W-1:0]      o_rdata
);

	logic [mem_port_pkg::DATA_W-1:0] words [logic [mem_port_pkg::WORD_ADDR_W-1:0]];
	logic                            ready_rand;
	logic                            read_pending;
	logic [mem_port_pkg::DATA_W-1:0] read_value;
	int                              read_delay;
	int                              init_count;

	initial begin
		o_init_done   = 1'b0;
		o_rdata_valid = 1'b0;
		o_rdata       = '0;
		ready_rand    = 1'b0;
		read_pending  = 1'b0;
		read_value    = '0;
		read_delay    = 0;
		init_count    = 0;
	end

	assign o_ready = ready_rand && !i_force_stall;

	always @(posedge i_clock) begin
		o_rdata_valid <= 1'b0;
		ready_rand    <= ($urandom_range(99) < 70);	// Ready on about 70 percent of cycles
		if (i_reset) begin
			init_count   <= 0;
			o_init_done  <= 1'b0;
			read_pending <= 1'b0;
		end
		else begin
			if (init_count < 10)
				init_count <= init_count + 1;
			else
				o_init_done <= 1'b1;

			if (o_ready && i_write_req)
				words[i_addr] = i_wdata;	// Visible to a read accepted later

			if (o_ready && i_read_req) begin
				read_pending <= 1'b1;
				read_value   <= words.exists(i_addr) ? words[i_addr] : '0;
				read_delay   <= $urandom_range(4, 1);
			end
			else if (read_pending) begin
				if (read_delay <= 1) begin
					o_rdata_valid <= 1'b1;
					o_rdata       <= read_value;
					read_pending  <= 1'b0;
				end
				else begin
					read_delay <= read_delay - 1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== sim/mem_port_bridge_tb.sv ====
// Testbench for the bridge; host traffic over a few words is checked against a table of last writes
`timescale 1ns/100ps
`default_nettype none

module mem_port_bridge_tb;

	localparam int TIMEOUT = 100;	// Cycles allowed for one host access

	logic                                 clock;
	logic                                 reset;
	logic                                 host_request;
	logic                                 host_rw;
	logic [mem_port_pkg::ADDR_W-1:0]      host_address;
	logic [mem_port_pkg::DATA_W-1:0]      host_wdata;
	logic [mem_port_pkg::DATA_W-1:0]      host_rdata;
	logic                                 host_ready;
	logic                                 force_stall;
	logic                                 init_done;
	logic                                 avl_ready;
	logic                                 avl_rdata_valid;
	logic [mem_port_pkg::DATA_W-1:0]      avl_rdata;
	logic                                 avl_read_req;
	logic                                 avl_write_req;
	logic                                 avl_burstbegin;
	logic [mem_port_pkg::WORD_ADDR_W-1:0] avl_addr;
	logic [mem_port_pkg::DATA_W-1:0]      avl_wdata;

	logic [mem_port_pkg::DATA_W-1:0] ref_words [logic [mem_port_pkg::WORD_ADDR_W-1:0]];
	logic [mem_port_pkg::WORD_ADDR_W-1:0] exp_write_addr [$];
	logic [mem_port_pkg::DATA_W-1:0]      exp_write_data [$];
	logic [mem_port_pkg::WORD_ADDR_W-1:0] read_addr_seen;
	int                              errors;
	int                              tests_run;
	int                              tests_failed;
	int                              writes_seen;
	int                              i;
	int                              n;
	int                              start;
	int                              acks;
	int                              seen_before;
	logic                            acked;
	logic [mem_port_pkg::DATA_W-1:0] data;
	logic [mem_port_pkg::DATA_W-1:0] rdata;

	tb_clock_gen clk_gen (.o_clock(clock));

	mem_port_bridge uut (
		.i_clock (clock), .i_reset (reset),
		.i_request (host_request), .i_rw (host_rw),
		.i_address (host_address), .i_wdata (host_wdata),
		.o_rdata (host_rdata), .o_ready (host_ready),
		.i_local_init_done (init_done), .i_avl_ready (avl_ready),
		.i_avl_rdata_valid (avl_rdata_valid), .i_avl_rdata (avl_rdata),
		.o_avl_read_req (avl_read_req), .o_avl_write_req (avl_write_req),
		.o_avl_burstbegin (avl_burstbegin), .o_avl_addr (avl_addr),
		.o_avl_wdata (avl_wdata)
	);

	avl_memory_model mem_model (
		.i_clock (clock), .i_reset (reset), .i_force_stall (force_stall),
		.i_read_req (avl_read_req), .i_write_req (avl_write_req),
		.i_addr (avl_addr), .i_wdata (avl_wdata),
		.o_init_done (init_done), .o_ready (avl_ready),
		.o_rdata_valid (avl_rdata_valid), .o_rdata (avl_rdata)
	);

	// ============================================================
	// Controller port monitors
	// ============================================================
	always @(negedge clock) begin
		if (avl_burstbegin !== (avl_read_req || avl_write_req)) begin
			$display("CHECK FAILED at %0t: burst-begin does not follow the requests", $time);
			errors++;
		end
		if (avl_read_req && avl_write_req) begin
			$display("CHECK FAILED at %0t: read and write requests both high", $time);
			errors++;
		end
	end

	always @(posedge clock) begin
		if (!reset && avl_write_req && avl_ready) begin
			writes_seen++;	// Writes taken by the controller
			if (exp_write_addr.size() == 0) begin
				$display("Controller took a write that the host never posted");
				errors++;
			end
			else begin
				if (avl_addr !== exp_write_addr[0] || avl_wdata !== exp_write_data[0]) begin
					$display("CHECK FAILED at %0t: write to word %h data %h, expected %h data %h",
					         $time, avl_addr, avl_wdata, exp_write_addr[0], exp_write_data[0]);
					errors++;
				end
				void'(exp_write_addr.pop_front());
				void'(exp_write_data.pop_front());
			end
		end
		if (!reset && avl_read_req && avl_ready)
			read_addr_seen = avl_addr;	// Word address of the last read taken
	end

	// ============================================================
	// Host tasks
	// ============================================================
	task automatic host_access(input logic rw, input logic [31:0] addr, input logic [31:0] wd,
	                           input int limit, output logic [31:0] rd, output logic ok);
		int k;
		host_request = 1'b1;
		host_rw      = rw;
		host_address = addr;
		host_wdata   = wd;
		ok           = 1'b0;
		rd           = '0;
		for (k = 0; k < limit && !ok; k++) begin
			@(negedge clock);
			if (host_ready) begin
				ok = 1'b1;
				rd = host_rdata;
			end
		end
		host_request = 1'b0;	// Dropped before the next edge so it is not taken again
	endtask

	// Posted writes reach the controller in host order
	task automatic record_write(input logic [31:0] addr, input logic [31:0] wd);
		ref_words[addr[28:2]] = wd;
		exp_write_addr.push_back(addr[28:2]);
		exp_write_data.push_back(wd);
	endtask

	task automatic do_write(input logic [31:0] addr, input logic [31:0] wd);
		logic [31:0] unused;
		logic        ok;
		host_access(1'b1, addr, wd, TIMEOUT, unused, ok);
		if (!ok) begin
			$display("Write to address %h got no ready within %0d cycles", addr, TIMEOUT);
			errors++;
		end
		else begin
			record_write(addr, wd);
		end
	endtask

	task automatic do_read(input logic [31:0] addr);
		logic [31:0] got;
		logic [31:0] expected;
		logic        ok;
		expected = ref_words.exists(addr[28:2]) ? ref_words[addr[28:2]] : '0;
		read_addr_seen = 'x;
		host_access(1'b0, addr, '0, TIMEOUT, got, ok);
		if (!ok) begin
			$display("Read of address %h got no ready within %0d cycles", addr, TIMEOUT);
			errors++;
		end
		else begin
			if (got !== expected) begin
				$display("CHECK FAILED at %0t: read %h returned %h, expected %h",
				         $time, addr, got, expected);
				errors++;
			end
			if (read_addr_seen !== addr[28:2]) begin
				$display("CHECK FAILED at %0t: read %h went to word %h, expected %h",
				         $time, addr, read_addr_seen, addr[28:2]);
				errors++;
			end
		end
	endtask

	task automatic random_traffic(input int count);
		int          k;
		logic [31:0] a;
		for (k = 0; k < count; k++) begin
			a = $urandom_range(15) << 2;
			if ($urandom_range(1) == 1)
				do_write(a, $urandom());
			else
				do_read(a);
			repeat ($urandom_range(3)) @(negedge clock);	// Random gap between requests
		end
	endtask

	task automatic apply_reset();
		reset = 1'b1;
		repeat (2) @(negedge clock);
		reset = 1'b0;
	endtask

	task automatic wait_init_done();
		int k;
		for (k = 0; k < 50 && !init_done; k++) begin
			if (avl_read_req || avl_write_req) begin
				$display("CHECK FAILED at %0t: controller request before init-done", $time);
				errors++;
			end
			@(negedge clock);
		end
		if (!init_done) begin
			$display("Init-done never rose after reset");
			errors++;
		end
	endtask

	task automatic check_idle_outputs();
		if (host_ready || avl_read_req || avl_write_req || avl_burstbegin) begin
			$display("CHECK FAILED at %0t: outputs not idle after reset", $time);
			errors++;
		end
	endtask

	task automatic finish_test(input string name, input int first_error);
		tests_run++;
		if (errors == first_error) begin
			$display("Test %0d, %s: passed", tests_run, name);
		end
		else begin
			tests_failed++;
			$display("Test %0d, %s: failed", tests_run, name);
		end
	endtask

	// ============================================================
	// Test sequence
	// ============================================================
	initial begin
		void'($urandom(32'h899b));
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		writes_seen  = 0;
		host_request = 1'b0;
		host_rw      = 1'b0;
		host_address = '0;
		host_wdata   = '0;
		force_stall  = 1'b0;
		apply_reset();

		start = errors;
		check_idle_outputs();
		do_write(32'h0000_0010, 32'ha5a5_0001);	// Posted while init-done is still low
		wait_init_done();
		for (n = 0; n < TIMEOUT && !avl_write_req; n++)
			@(negedge clock);
		if (!avl_write_req) begin
			$display("Held write never reached the controller after init-done");
			errors++;
		end
		finish_test("init-done hold-off", start);

		start = errors;
		do_write(32'h0000_0020, 32'h1234_5678);
		do_read(32'h0000_0020);
		finish_test("write then read", start);

		start = errors;
		random_traffic(200);
		finish_test("random traffic", start);

		start = errors;
		do_write(32'h4000_0040, 32'hcafe_0040);
		do_read(32'h0000_0040);
		do_write(32'h0000_0051, 32'hbeef_0050);
		do_read(32'h0000_0050);
		finish_test("address aliasing", start);

		start       = errors;
		force_stall = 1'b1;
		seen_before = writes_seen;
		acks        = 0;
		acked       = 1'b1;
		for (i = 0; i < 2 * mem_port_pkg::QUEUE_DEPTH + 2 && acked; i++) begin
			data = $urandom();
			host_access(1'b1, 32'h200 + i * 4, data, 20, rdata, acked);
			if (acked) begin
				record_write(32'h200 + i * 4, data);
				acks++;
			end
		end
		if (acks > mem_port_pkg::QUEUE_DEPTH + 1) begin
			$display("CHECK FAILED at %0t: %0d writes acked while stalled", $time, acks);
			errors++;
		end
		if (acked) begin
			$display("Writes were never held off while the controller stalled");
			errors++;
		end
		force_stall = 1'b0;
		for (i = 0; i < acks; i++)
			do_read(32'h200 + i * 4);
		if (writes_seen - seen_before != acks) begin
			$display("CHECK FAILED at %0t: controller took %0d writes, expected %0d",
			         $time, writes_seen - seen_before, acks);
			errors++;
		end
		finish_test("back-pressure", start);

		start       = errors;
		force_stall = 1'b1;
		for (i = 0; i < 3; i++)
			host_access(1'b1, 32'h300 + i * 4, $urandom(), 20, rdata, acked);	// Lost at reset
		apply_reset();
		force_stall = 1'b0;
		check_idle_outputs();
		wait_init_done();
		random_traffic(60);
		finish_test("reset in mid-traffic", start);

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0 && tests_failed == 0) begin
			$display("=== PASS ===");
		end
		else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== mem_port_bridge.f ====
design/mem_port_pkg.sv
design/cmd_queue_if.sv
design/host_request_sequencer.sv
design/cmd_queue.sv
design/avl_port_driver.sv
design/mem_port_bridge.sv
sim/tb_clock_gen.sv
sim/avl_memory_model.sv
sim/mem_port_bridge_tb.sv
